/* Makefile */
TOP = corr_bus_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps \
		-f corr_bus.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f corr_bus.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* burst/beat_packer.sv */
`default_nettype none

module beat_packer
   import corr_bus_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  slot_list_t slots,
   input  beat_num_t  beat_num,
   output beat_t      beat
);

   beat_t beat_sel;
   beat_t beat_a;

   // Beat 0 is the idle beat, beats 1 to 7 each carry six consecutive slots
   always_comb
   begin
      int base;

      base     = 0;
      beat_sel = '0;

      if (beat_num != '0)
      begin
         base         = beat_base(beat_num);
         beat_sel.num = beat_num;
         for (int w = 0; w < WORDS_PER_BEAT; w++)
         begin
            beat_sel.words[w] = slots[base + w];
         end
      end
   end

   // Stage A registers the selected beat
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         beat_a <= '0;
      end
      else
      begin
         beat_a <= beat_sel;
      end
   end

   // Stage B drives the bus
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         beat <= '0;
      end
      else
      begin
         beat <= beat_a;
      end
   end

   // Idle beats on the bus never carry stale data
   a_idle_zero : assert property (
      @(posedge clk) disable iff (rst)
      (beat.num == '0) |-> (beat.words == '0)
   );

endmodule

`default_nettype wire

/* burst/beat_scheduler.sv */
`default_nettype none

module beat_scheduler
   import corr_bus_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  logic      new_frame,
   output beat_num_t beat_num
);

   seq_cnt_t seq_cnt;

   // Counts 1 through LAST_BEAT after a strobe, then parks at SEQ_IDLE
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         seq_cnt <= '0;
      end
      else if (new_frame)
      begin
         seq_cnt <= seq_cnt_t'(1);   // A strobe mid-burst starts over
      end
      else if ((seq_cnt != '0) && (seq_cnt != seq_cnt_t'(SEQ_IDLE)))   // Zero waits for a strobe
      begin
         seq_cnt <= seq_cnt + seq_cnt_t'(1);
      end
   end

   // SEQ_IDLE drops its top bit and reads as beat 0
   assign beat_num = seq_cnt[BEAT_NUM_W-1:0];

   a_seq_range : assert property (
      @(posedge clk) disable iff (rst)
      seq_cnt <= seq_cnt_t'(SEQ_IDLE)
   );

endmodule

`default_nettype wire

/* common/corr_bus_pkg.sv */
`default_nettype none

package corr_bus_pkg;

   localparam int CORR_W         = 8;   // One correlation result and one bus word
   localparam int ADDR_W         = 19;
   localparam int N_S05          = 6;
   localparam int N_S10          = 11;
   localparam int N_S20          = 21;
   localparam int WORDS_PER_BEAT = 6;
   localparam int LAST_BEAT      = 7;
   localparam int SEQ_IDLE       = LAST_BEAT + 1;   // Saturation value, reads as beat 0
   localparam int BEAT_NUM_W     = 3;
   localparam int SEQ_W          = 4;

   // Header occupies the first three slots of a burst
   localparam int N_HDR_SLOTS    = 3;
   localparam int SLOT_ADDR_LO   = 0;
   localparam int SLOT_ADDR_MID  = 1;
   localparam int SLOT_ADDR_HI   = 2;

   // First slot of each result group in send order
   localparam int S05_BASE       = N_HDR_SLOTS;
   localparam int S10_BASE       = S05_BASE + N_S05;
   localparam int S20_BASE       = S10_BASE + N_S10;
   localparam int PAD_SLOT       = S20_BASE + N_S20;
   localparam int N_SLOTS        = PAD_SLOT + 1;   // 42 slots fill seven beats exactly

   typedef logic [CORR_W-1:0]     corr_t;
   typedef logic [BEAT_NUM_W-1:0] beat_num_t;
   typedef logic [SEQ_W-1:0]      seq_cnt_t;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic              comp_switch;
   } frame_hdr_t;

   typedef struct packed {
      corr_t [N_S05-1:0] s05;
      corr_t [N_S10-1:0] s10;
      corr_t [N_S20-1:0] s20;
   } corr_set_t;

   typedef corr_t [N_SLOTS-1:0] slot_list_t;

   // Word 1 of the bus sits at index 0
   typedef corr_t [WORDS_PER_BEAT-1:0] beat_words_t;

   typedef struct packed {
      beat_num_t   num;
      beat_words_t words;
   } beat_t;

   // First slot carried by data beat num, valid for 1 to LAST_BEAT
   function automatic int beat_base(beat_num_t num);
      return (int'(num) - 1) * WORDS_PER_BEAT;
   endfunction

endpackage

`default_nettype wire

/* corr_bus.f */
+incdir+tb
common/corr_bus_pkg.sv
hdl/corr_snapshot.sv
burst/beat_scheduler.sv
burst/beat_packer.sv
hdl/corr_bus_top.sv
tb/corr_bus_tb.sv

/* hdl/corr_bus_top.sv */
`default_nettype none

module corr_bus_top
   import corr_bus_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic       new_frame,
   input  frame_hdr_t hdr,
   input  corr_set_t  corr,
   output beat_t      beat
);

   slot_list_t slots;
   beat_num_t  beat_num;

   // Holds the captured frame in send order
   corr_snapshot snapshot_i (
      .clk       (clk),
      .rst       (rst),
      .new_frame (new_frame),
      .hdr       (hdr),
      .corr      (corr),
      .slots     (slots)
   );

   // Both the snapshot and the counter act on the same strobe edge
   beat_scheduler scheduler_i (
      .clk       (clk),
      .rst       (rst),
      .new_frame (new_frame),
      .beat_num  (beat_num)
   );

   // Two register stages, so beat n reaches the bus after edge t+n+1
   beat_packer packer_i (
      .clk      (clk),
      .rst      (rst),
      .slots    (slots),
      .beat_num (beat_num),
      .beat     (beat)
   );

endmodule

`default_nettype wire

/* hdl/corr_snapshot.sv */
`default_nettype none

module corr_snapshot
   import corr_bus_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic       new_frame,
   input  frame_hdr_t hdr,
   input  corr_set_t  corr,
   output slot_list_t slots
);

   frame_hdr_t hdr_q;
   corr_set_t  corr_q;

   // Frame is held until the next strobe so a burst always reads one snapshot
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         hdr_q  <= '0;
         corr_q <= '0;
      end
      else if (new_frame)
      begin
         hdr_q  <= hdr;
         corr_q <= corr;
      end
   end

   always_comb
   begin
      slots = '0;

      slots[SLOT_ADDR_LO]  = hdr_q.addr[7:0];
      slots[SLOT_ADDR_MID] = hdr_q.addr[15:8];
      slots[SLOT_ADDR_HI]  = {hdr_q.addr[ADDR_W-1:16], hdr_q.comp_switch, 4'b0000};

      for (int i = 0; i < N_S05; i++)
      begin
         slots[S05_BASE + i] = corr_q.s05[i];
      end

      for (int i = 0; i < N_S10; i++)
      begin
         slots[S10_BASE + i] = corr_q.s10[i];
      end

      for (int i = 0; i < N_S20; i++)
      begin
         slots[S20_BASE + i] = corr_q.s20[i];
      end

      slots[PAD_SLOT] = '0;   // Last word of beat 7 is padding
   end

   // The receiver relies on the zero nibble and zero pad to frame the burst
   a_zero_fill : assert property (
      @(posedge clk)
      (slots[PAD_SLOT] == '0) && (slots[SLOT_ADDR_HI][3:0] == 4'b0000)
   );

endmodule

`default_nettype wire

/* tb/corr_bus_ref.svh */
`ifndef CORR_BUS_REF_SVH
`define CORR_BUS_REF_SVH

// Builds the beat the bus should carry for a captured frame and a beat number
function automatic beat_t expected_beat(frame_hdr_t h, corr_set_t c, beat_num_t n);
   corr_t list [0:N_SLOTS-1];
   beat_t b;
   int    base;

   b = '0;

   list[0] = h.addr[7:0];
   list[1] = h.addr[15:8];
   list[2] = {h.addr[18:16], h.comp_switch, 4'h0};   // Low nibble is always zero

   for (int i = 0; i < 6; i++)
   begin
      list[3 + i] = c.s05[i];
   end
   for (int i = 0; i < 11; i++)
   begin
      list[9 + i] = c.s10[i];
   end
   for (int i = 0; i < 21; i++)
   begin
      list[20 + i] = c.s20[i];
   end
   list[41] = '0;   // Pad word at the end of beat 7

   if (n != beat_num_t'(0))
   begin
      base  = 6 * (int'(n) - 1);
      b.num = n;
      for (int w = 0; w < 6; w++)
      begin
         b.words[w] = list[base + w];
      end
   end
   return b;
endfunction

task automatic check_num(input string name, input beat_num_t got, input beat_num_t exp);
   if (got !== exp)
   begin
      err_num++;
      $display("FAIL %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
   end
endtask

task automatic check_word(input string name, input corr_t got, input corr_t exp);
   if (got !== exp)
   begin
      err_word++;
      $display("FAIL %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
   end
endtask

`endif

/* tb/corr_bus_tb.sv */
`default_nettype none

module corr_bus_tb
   import corr_bus_pkg::*;
;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int RESET_CYCLES = 10;
   localparam int IDLE_CYCLES  = 10;
   localparam int BURST_CYCLES = 12;   // Strobe plus seven beats plus the return to idle
   localparam int N_RANDOM     = 20;
   localparam int N_RESTART    = 5;
   localparam int HOLD_CYCLES  = 5;
   localparam int N_BURSTS     = N_RANDOM + 4 + 1 + 2 * N_RESTART + 1;
   localparam int STIM_CYCLES  = RESET_CYCLES + 2 * IDLE_CYCLES + N_BURSTS * BURST_CYCLES
                                 + HOLD_CYCLES;
   localparam int TIMEOUT_CYCLES = STIM_CYCLES + 50;

   logic       clk;
   logic       rst;
   logic       new_frame;
   frame_hdr_t hdr;
   corr_set_t  corr;
   beat_t      beat;

   frame_hdr_t hdr_m;
   corr_set_t  corr_m;
   int         cnt_m;
   beat_t      pipe_m [$];
   beat_t      exp_beat;

   int cycles   = 0;
   int n_checks = 0;
   int err_num  = 0;
   int err_word = 0;
   int err_other = 0;

   `include "corr_bus_ref.svh"

   corr_bus_top dut_i (
      .clk       (clk),
      .rst       (rst),
      .new_frame (new_frame),
      .hdr       (hdr),
      .corr      (corr),
      .beat      (beat)
   );

   initial clk = 1'b0;
   always #20 clk = ~clk;

   // Model of capture and counter, delayed by the two packer stages
   always @(posedge clk)
   begin
      beat_t sel;

      if (rst)
      begin
         hdr_m    = '0;
         corr_m   = '0;
         cnt_m    = 0;
         pipe_m   = '{beat_t'(0), beat_t'(0)};
         exp_beat = '0;
      end
      else
      begin
         if (new_frame)
         begin
            hdr_m  = hdr;
            corr_m = corr;
            cnt_m  = 1;
         end
         else if ((cnt_m != 0) && (cnt_m < SEQ_IDLE))   // No burst before the first strobe
         begin
            cnt_m = cnt_m + 1;
         end
         sel = expected_beat(hdr_m, corr_m,
                             (cnt_m == SEQ_IDLE) ? beat_num_t'(0) : beat_num_t'(cnt_m));
         pipe_m.push_back(sel);
         exp_beat = pipe_m.pop_front();
      end
   end

   always @(negedge clk)
   begin
      if (cycles > 0)
      begin
         check_num("beat.num", beat.num, exp_beat.num);
         for (int w = 0; w < WORDS_PER_BEAT; w++)
         begin
            check_word($sformatf("beat.words[%0d]", w + 1), beat.words[w], exp_beat.words[w]);
         end
         n_checks++;
      end
   end

   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycles >= TIMEOUT_CYCLES)
      begin
         $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Error counts: num %0d, word %0d, other %0d", err_num, err_word, err_other);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   task automatic step();
      @(posedge clk);
      #5;   // Inputs change well clear of the edge
   endtask

   task automatic wait_for_num(input beat_num_t n);
      while (beat.num != n)
      begin
         step();
      end
   endtask

   function automatic frame_hdr_t rand_hdr();
      frame_hdr_t h;

      h.addr        = ADDR_W'($urandom);
      h.comp_switch = 1'($urandom);
      return h;
   endfunction

   function automatic corr_set_t rand_corr();
      corr_set_t c;

      for (int i = 0; i < N_S05; i++)
      begin
         c.s05[i] = corr_t'($urandom);
      end
      for (int i = 0; i < N_S10; i++)
      begin
         c.s10[i] = corr_t'($urandom);
      end
      for (int i = 0; i < N_S20; i++)
      begin
         c.s20[i] = corr_t'($urandom);
      end
      return c;
   endfunction

   task automatic send_frame(input frame_hdr_t h, input corr_set_t c);
      hdr       = h;
      corr      = c;
      new_frame = 1'b1;
      step();
      new_frame = 1'b0;
   endtask

   // A burst is over once beat 7 has passed and the idle beat is back
   task automatic finish_burst();
      wait_for_num(beat_num_t'(LAST_BEAT));
      wait_for_num(beat_num_t'(0));
   endtask

   task automatic header_case(input logic [ADDR_W-1:0] addr, input logic sw);
      frame_hdr_t h;

      h.addr        = addr;
      h.comp_switch = sw;
      send_frame(h, rand_corr());
      finish_burst();
   endtask

   initial
   begin
      int d;

      rst       = 1'b1;
      new_frame = 1'b0;
      hdr       = '0;
      corr      = '0;
      void'($urandom(47));

      repeat (RESET_CYCLES) step();
      rst = 1'b0;
      repeat (IDLE_CYCLES) step();

      for (int k = 0; k < N_RANDOM; k++)
      begin
         send_frame(rand_hdr(), rand_corr());
         finish_burst();
      end

      header_case(19'h7ffff, 1'b0);
      header_case(19'h7ffff, 1'b1);
      header_case(19'h55555, 1'b0);
      header_case(19'h2aaaa, 1'b1);

      // Inputs wander during the burst while no strobe comes
      send_frame(rand_hdr(), rand_corr());
      repeat (6)
      begin
         hdr  = rand_hdr();
         corr = rand_corr();
         step();
      end
      finish_burst();

      for (int k = 0; k < N_RESTART; k++)
      begin
         d = 1 + int'($urandom % 5);
         send_frame(rand_hdr(), rand_corr());
         repeat (d - 1) step();
         send_frame(rand_hdr(), rand_corr());
         finish_burst();
      end

      new_frame = 1'b1;
      repeat (HOLD_CYCLES)
      begin
         hdr  = rand_hdr();
         corr = rand_corr();
         step();
      end
      new_frame = 1'b0;
      finish_burst();

      repeat (IDLE_CYCLES) step();

      if (n_checks == 0)
      begin
         err_other++;
         $display("No beats were compared during the run");
      end
      $display("Error counts: num %0d, word %0d, other %0d", err_num, err_word, err_other);
      if (err_num + err_word + err_other == 0)
      begin
         $display("NO ERRORS");
      end
      else
      begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire
